//--- src/rx_params.svh
// frame layout, buffer sizing and RAM address widths; include in every receiver source
`ifndef RX_PARAMS_SVH
`define RX_PARAMS_SVH

// ------------------------------
// frame layout
// ------------------------------
// header is DA FC MODE then ADDR high to low
`define RX_HDR_BYTES 6
// command bytes open the payload
`define RX_CMD_BYTES 6
// data bytes follow the command bytes
`define RX_DATA_BYTES 32
`define RX_PAY_BYTES (`RX_CMD_BYTES + `RX_DATA_BYTES)
// fixed length on the link
`define RX_FRAME_BYTES 44

// ------------------------------
// buffering
// ------------------------------
// slot count, also the link's starting credits
`define RX_SLOTS 2
`define RX_SLOT_W 1
// byte position within one frame or slot
`define RX_OFS_W 6
`define RX_BUF_AW (`RX_SLOT_W + `RX_OFS_W)

// ------------------------------
// RAM side
// ------------------------------
`define RX_ADDR_W 24
// download data lands above the command bytes
`define RX_LOAD_DATA_OFS 8
// back to back reset frames for one card reset
`define RX_RESET_RUN 4

`endif

//--- src/rx_frame_pkg.sv
// link frame types for the receiver; import wherever link bytes or header fields are handled
`include "rx_params.svh"

package rx_frame_pkg;

   // ------------------------------
   // decoded header fields
   // ------------------------------
   // function codes the card knows
   typedef enum logic [7:0] {
      fc_other = 8'h00,
      fc_data  = 8'h60,
      fc_reset = 8'hff
   } rx_fc_e;

   // raw 0 and 1 get console handling
   typedef enum logic [1:0] {
      mode_run,
      mode_console,
      mode_download
   } rx_mode_e;

   // ------------------------------
   // link side
   // ------------------------------
   // one transfer from the deserializer
   typedef struct packed {
      logic [7:0] data;
      // marks the final byte
      logic       last;
      // verdict valid on the final byte only
      logic       crc_ok;
   } rx_link_byte_t;

   // header bytes as they came in
   typedef struct packed {
      logic [7:0]            da;
      logic [7:0]            fc;
      logic [7:0]            mode;
      logic [`RX_ADDR_W-1:0] addr;
   } rx_header_t;

endpackage

//--- src/rx_store_pkg.sv
// types for buffered frames and RAM writes; import in the stages and at the top level
`include "rx_params.svh"

package rx_store_pkg;
   import rx_frame_pkg::*;

   // which local RAM takes a write
   typedef enum logic [1:0] {
      tgt_cmd,
      tgt_cdata,
      tgt_load
   } rx_target_e;

   // header plus the slot holding its payload
   typedef struct packed {
      rx_header_t            hdr;
      logic [`RX_SLOT_W-1:0] slot;
   } rx_slot_hdr_t;

   // one accepted frame for the writer
   typedef struct packed {
      logic [`RX_SLOT_W-1:0] slot;
      // console or download only
      rx_mode_e              mode;
      logic [`RX_ADDR_W-1:0] addr;
   } rx_write_desc_t;

   // single byte write into one RAM
   typedef struct packed {
      rx_target_e            target;
      logic [`RX_ADDR_W-1:0] addr;
      logic [7:0]            data;
   } rx_ram_wr_t;

   // raw mode and address for the tx side
   typedef struct packed {
      logic [7:0]            mode;
      logic [`RX_ADDR_W-1:0] addr;
   } rx_notice_t;

endpackage

//--- src/rx_frame_store.sv
// first receive stage; captures link frames into two slots and returns link credits
`timescale 1ns/100ps
`include "rx_params.svh"

module rx_frame_store
   import rx_frame_pkg::*, rx_store_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   // link side
   input  logic                   link_valid,
   input  rx_link_byte_t          link_byte,
   output logic                   link_credit,
   output logic                   crc_err,
   // header towards dispatch
   output logic                   hdr_valid,
   output rx_slot_hdr_t           hdr,
   // slot release sources
   input  logic                   drop_valid,
   input  logic [`RX_SLOT_W-1:0]  drop_slot,
   input  logic                   release_valid,
   input  logic [`RX_SLOT_W-1:0]  release_slot,
   // payload read port for the writer
   input  logic                   buf_rd,
   input  logic [`RX_BUF_AW-1:0]  buf_raddr,
   output logic [7:0]             buf_rdata
);

   logic [`RX_SLOTS-1:0]         free_map;
   logic [`RX_SLOTS-1:0]         rel_mask;
   logic [`RX_SLOT_W-1:0]        alloc_slot;
   logic [`RX_SLOT_W-1:0]        cur_slot;
   logic [`RX_SLOT_W-1:0]        hdr_slot_q;
   logic [`RX_OFS_W-1:0]         wr_ptr;
   logic [8*`RX_HDR_BYTES-1:0]   hdr_shift;
   logic [`RX_SLOT_W:0]          rel_cnt;
   logic [`RX_SLOT_W:0]          credit_pend;
   logic [`RX_SLOT_W:0]          credit_sum;
   logic                         first_byte;
   logic                         end_byte;
   logic [7:0]                   buf_mem [2**`RX_BUF_AW];

   // link spent a credit, so a free slot exists
   assign first_byte = link_valid && (wr_ptr == '0);
   assign end_byte   = link_valid &&
                       (link_byte.last || wr_ptr == `RX_OFS_W'(`RX_FRAME_BYTES - 1));

   // lowest free slot wins
   always_comb
   begin
      alloc_slot = '0;
      for (int i = `RX_SLOTS - 1; i >= 0; i--)
         if (free_map[i])
            alloc_slot = i[`RX_SLOT_W-1:0];
   end

   // ------------------------------
   // byte capture
   // ------------------------------
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr     <= '0;
         cur_slot   <= '0;
         hdr_valid  <= 1'b0;
         crc_err    <= 1'b0;
         hdr_slot_q <= '0;
      end
      else
      begin
         hdr_valid <= end_byte && link_byte.crc_ok;
         crc_err   <= end_byte && !link_byte.crc_ok;
         if (first_byte)
            cur_slot <= alloc_slot;
         if (end_byte)
         begin
            wr_ptr     <= '0;
            hdr_slot_q <= cur_slot;
         end
         else if (link_valid)
            wr_ptr <= wr_ptr + 1'b1;
      end
   end

   // header bytes shift in, DA ends up on top
   always_ff @(posedge clk)
   begin
      if (link_valid && wr_ptr < `RX_OFS_W'(`RX_HDR_BYTES))
         hdr_shift <= {hdr_shift[8*`RX_HDR_BYTES-9:0], link_byte.data};
   end

   assign hdr.hdr  = rx_header_t'(hdr_shift);
   assign hdr.slot = hdr_slot_q;

   // ------------------------------
   // slot memory
   // ------------------------------
   // payload offset 0 is frame byte 6
   always_ff @(posedge clk)
   begin
      if (link_valid && wr_ptr >= `RX_OFS_W'(`RX_HDR_BYTES))
         buf_mem[{cur_slot, wr_ptr - `RX_OFS_W'(`RX_HDR_BYTES)}] <= link_byte.data;
      if (buf_rd)
         buf_rdata <= buf_mem[buf_raddr];
   end

   // ------------------------------
   // slot release and credits
   // ------------------------------
   // bad crc frees its slot in the crc_err cycle
   always_comb
   begin
      rel_mask = '0;
      if (crc_err)
         rel_mask[hdr_slot_q] = 1'b1;
      if (drop_valid)
         rel_mask[drop_slot] = 1'b1;
      if (release_valid)
         rel_mask[release_slot] = 1'b1;
      rel_cnt = '0;
      for (int i = 0; i < `RX_SLOTS; i++)
         rel_cnt = rel_cnt + rel_mask[i];
      credit_sum = credit_pend + rel_cnt;
   end

   // one credit pulse per cycle, extra ones queue up
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         free_map    <= '1;
         credit_pend <= '0;
         link_credit <= 1'b0;
      end
      else
      begin
         free_map <= (free_map | rel_mask) &
                     ~(first_byte ? (`RX_SLOTS'(1) << alloc_slot) : '0);
         link_credit <= (credit_sum != '0);
         if (credit_sum != '0)
            credit_pend <= credit_sum - 1'b1;
         else
            credit_pend <= '0;
      end
   end

endmodule

//--- src/rx_frame_dispatch.sv
// second receive stage; judges each stored header and hands accepted frames to the writer
`timescale 1ns/100ps
`include "rx_params.svh"

module rx_frame_dispatch
   import rx_frame_pkg::*, rx_store_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   init_done,
   input  logic [2:0]             rack_id,
   input  logic [3:0]             slot_id,
   // header from the store
   input  logic                   hdr_valid,
   input  rx_slot_hdr_t           hdr,
   // dropped frames go back to the store
   output logic                   drop_valid,
   output logic [`RX_SLOT_W-1:0]  drop_slot,
   // writer handshake
   output logic                   desc_valid,
   output rx_write_desc_t         desc,
   input  logic                   desc_credit,
   // tx notice and card reset
   output logic                   notice_valid,
   output rx_notice_t             notice,
   output logic                   card_reset
);

   rx_slot_hdr_t           q_mem [`RX_SLOTS];
   logic [`RX_SLOT_W-1:0]  q_wr;
   logic [`RX_SLOT_W-1:0]  q_rd;
   logic [`RX_SLOT_W:0]    q_cnt;
   rx_slot_hdr_t           head;
   rx_fc_e                 head_fc;
   rx_mode_e               head_mode;
   logic                   init_q;
   logic                   station_ok;
   logic [7:0]             station;
   logic                   credit;
   logic [2:0]             run_cnt;
   logic                   da_ok;
   logic                   mode_ok;
   logic                   accept_data;
   logic                   accept_reset;
   logic                   take;

   function automatic rx_fc_e fc_decode(input logic [7:0] raw);
      case (raw)
         8'h60:   return fc_data;
         8'hff:   return fc_reset;
         default: return fc_other;
      endcase
   endfunction

   // raw values above 2 are caught by mode_ok
   function automatic rx_mode_e mode_decode(input logic [7:0] raw);
      case (raw)
         8'd0:    return mode_run;
         8'd1:    return mode_console;
         default: return mode_download;
      endcase
   endfunction

   // ------------------------------
   // station address
   // ------------------------------
   // rack*12 + 14 - slot, wraps at 256
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         init_q     <= 1'b0;
         station_ok <= 1'b0;
         station    <= '0;
      end
      else
      begin
         init_q <= init_done;
         if (init_done && !init_q)
         begin
            station_ok <= 1'b1;
            station    <= {5'd0, rack_id} * 8'd12 + 8'd14 - {4'd0, slot_id};
         end
      end
   end

   // ------------------------------
   // header queue
   // ------------------------------
   // depth RX_SLOTS, the store never has more frames out
   always_ff @(posedge clk)
   begin
      if (hdr_valid)
         q_mem[q_wr] <= hdr;
   end

   assign head      = q_mem[q_rd];
   assign head_fc   = fc_decode(head.hdr.fc);
   assign head_mode = mode_decode(head.hdr.mode);

   // decision on the queue head
   always_comb
   begin
      da_ok        = station_ok && (head.hdr.da == station);
      mode_ok      = head.hdr.mode <= 8'd2;
      accept_data  = da_ok && (head_fc == fc_data) && mode_ok;
      accept_reset = da_ok && (head_fc == fc_reset);
      // data frames wait for a writer credit, drops never do
      take         = (q_cnt != '0) && (!accept_data || credit);
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         q_wr         <= '0;
         q_rd         <= '0;
         q_cnt        <= '0;
         credit       <= 1'b1;
         run_cnt      <= '0;
         drop_valid   <= 1'b0;
         desc_valid   <= 1'b0;
         notice_valid <= 1'b0;
         card_reset   <= 1'b0;
      end
      else
      begin
         if (hdr_valid)
            q_wr <= q_wr + 1'b1;
         if (take)
            q_rd <= q_rd + 1'b1;
         q_cnt <= q_cnt + hdr_valid - take;

         drop_valid   <= take && !accept_data;
         desc_valid   <= take && accept_data;
         notice_valid <= take && accept_data;
         card_reset   <= 1'b0;
         credit       <= (credit && !(take && accept_data)) || desc_credit;

         // reset run, cleared by a card reset or an accepted data frame
         if (take && accept_reset)
         begin
            if (run_cnt == 3'(`RX_RESET_RUN - 1))
            begin
               card_reset <= 1'b1;
               run_cnt    <= '0;
            end
            else
               run_cnt <= run_cnt + 1'b1;
         end
         else if (take && accept_data)
            run_cnt <= '0;
      end
   end

   // payload of the outgoing pulses
   always_ff @(posedge clk)
   begin
      if (take)
      begin
         drop_slot   <= head.slot;
         desc.slot   <= head.slot;
         desc.mode   <= (head_mode == mode_download) ? mode_download : mode_console;
         desc.addr   <= head.hdr.addr;
         notice.mode <= head.hdr.mode;
         notice.addr <= head.hdr.addr;
      end
   end

endmodule

//--- src/rx_ram_writer.sv
// third receive stage; streams one buffered payload into the command, data or download RAM
`timescale 1ns/100ps
`include "rx_params.svh"

module rx_ram_writer
   import rx_frame_pkg::*, rx_store_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   // work from dispatch
   input  logic                   desc_valid,
   input  rx_write_desc_t         desc,
   output logic                   desc_credit,
   // slot buffer access
   output logic                   buf_rd,
   output logic [`RX_BUF_AW-1:0]  buf_raddr,
   input  logic [7:0]             buf_rdata,
   output logic                   release_valid,
   output logic [`RX_SLOT_W-1:0]  release_slot,
   // RAM write port
   output logic                   ram_wr_valid,
   output rx_ram_wr_t             ram_wr
);

   typedef enum logic [1:0] {
      st_idle,
      st_cmd,
      st_data,
      st_done
   } wr_state_e;

   wr_state_e              state;
   logic [`RX_SLOT_W-1:0]  slot_q;
   rx_mode_e               mode_q;
   logic [`RX_ADDR_W-1:0]  base_q;
   logic [`RX_OFS_W-1:0]   rd_idx;
   logic [`RX_OFS_W-1:0]   ret_idx;
   logic                   ret_valid;
   logic                   wr_last;
   rx_target_e             wr_tgt;
   logic [`RX_ADDR_W-1:0]  wr_addr;

   // ------------------------------
   // buffer reads
   // ------------------------------
   // byte 0 goes out with desc_valid, saves a cycle
   always_comb
   begin
      buf_rd    = 1'b0;
      buf_raddr = {slot_q, rd_idx};
      case (state)
         st_idle:
         begin
            buf_rd    = desc_valid;
            buf_raddr = {desc.slot, {`RX_OFS_W{1'b0}}};
         end
         st_cmd, st_data:
            buf_rd = 1'b1;
         default:
            buf_rd = 1'b0;
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state  <= st_idle;
         rd_idx <= '0;
      end
      else
      begin
         case (state)
            st_idle:
               if (desc_valid)
               begin
                  state  <= st_cmd;
                  rd_idx <= `RX_OFS_W'(1);
               end
            st_cmd:
            begin
               rd_idx <= rd_idx + 1'b1;
               if (rd_idx == `RX_OFS_W'(`RX_CMD_BYTES - 1))
                  state <= st_data;
            end
            st_data:
            begin
               rd_idx <= rd_idx + 1'b1;
               if (rd_idx == `RX_OFS_W'(`RX_PAY_BYTES - 1))
                  state <= st_done;
            end
            // wait for the write pipe to drain
            st_done:
               if (wr_last)
                  state <= st_idle;
            default:
               state <= st_idle;
         endcase
      end
   end

   // frame parameters held for the whole frame
   always_ff @(posedge clk)
   begin
      if (state == st_idle && desc_valid)
      begin
         slot_q <= desc.slot;
         mode_q <= desc.mode;
         base_q <= desc.addr;
      end
      ret_idx <= buf_raddr[`RX_OFS_W-1:0];
   end

   // ------------------------------
   // write addressing
   // ------------------------------
   // console cmd uses addr>>4, download data sits at addr+8
   always_comb
   begin
      if (ret_idx < `RX_OFS_W'(`RX_CMD_BYTES))
      begin
         if (mode_q == mode_download)
         begin
            wr_tgt  = tgt_load;
            wr_addr = base_q + `RX_ADDR_W'(ret_idx);
         end
         else
         begin
            wr_tgt  = tgt_cmd;
            wr_addr = (base_q >> 4) + `RX_ADDR_W'(ret_idx);
         end
      end
      else if (mode_q == mode_download)
      begin
         wr_tgt  = tgt_load;
         wr_addr = base_q + `RX_ADDR_W'(`RX_LOAD_DATA_OFS) +
                   `RX_ADDR_W'(ret_idx - `RX_OFS_W'(`RX_CMD_BYTES));
      end
      else
      begin
         wr_tgt  = tgt_cdata;
         wr_addr = base_q + `RX_ADDR_W'(ret_idx - `RX_OFS_W'(`RX_CMD_BYTES));
      end
   end

   // ------------------------------
   // write and finish pulses
   // ------------------------------
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         ret_valid     <= 1'b0;
         ram_wr_valid  <= 1'b0;
         wr_last       <= 1'b0;
         desc_credit   <= 1'b0;
         release_valid <= 1'b0;
      end
      else
      begin
         // read data shows up one cycle after buf_rd
         ret_valid     <= buf_rd;
         ram_wr_valid  <= ret_valid;
         wr_last       <= ret_valid && (ret_idx == `RX_OFS_W'(`RX_PAY_BYTES - 1));
         desc_credit   <= wr_last;
         release_valid <= wr_last;
      end
   end

   always_ff @(posedge clk)
   begin
      ram_wr.target <= wr_tgt;
      ram_wr.addr   <= wr_addr;
      ram_wr.data   <= buf_rdata;
   end

   // slot stays put until the next descriptor
   assign release_slot = slot_q;

endmodule

//--- src/rx_link_receiver.sv
// receive side top level; store, dispatch and RAM writer chained as a three stage pipeline
`timescale 1ns/100ps
`include "rx_params.svh"

module rx_link_receiver
   import rx_frame_pkg::*, rx_store_pkg::*;
(
   input  logic           clk,
   input  logic           reset,
   input  logic           init_done,
   input  logic [2:0]     rack_id,
   input  logic [3:0]     slot_id,
   // deserializer side
   input  logic           link_valid,
   input  rx_link_byte_t  link_byte,
   output logic           link_credit,
   output logic           crc_err,
   // local RAM writes
   output logic           ram_wr_valid,
   output rx_ram_wr_t     ram_wr,
   // to the transmit side
   output logic           notice_valid,
   output rx_notice_t     notice,
   output logic           card_reset
);

   // ------------------------------
   // stage to stage wiring
   // ------------------------------
   logic                   hdr_valid;
   rx_slot_hdr_t           hdr;
   logic                   drop_valid;
   logic [`RX_SLOT_W-1:0]  drop_slot;
   logic                   desc_valid;
   rx_write_desc_t         desc;
   logic                   desc_credit;
   logic                   release_valid;
   logic [`RX_SLOT_W-1:0]  release_slot;
   logic                   buf_rd;
   logic [`RX_BUF_AW-1:0]  buf_raddr;
   logic [7:0]             buf_rdata;

   rx_frame_store u_rx_frame_store (
      .clk           (clk),
      .reset         (reset),
      .link_valid    (link_valid),
      .link_byte     (link_byte),
      .link_credit   (link_credit),
      .crc_err       (crc_err),
      .hdr_valid     (hdr_valid),
      .hdr           (hdr),
      .drop_valid    (drop_valid),
      .drop_slot     (drop_slot),
      .release_valid (release_valid),
      .release_slot  (release_slot),
      .buf_rd        (buf_rd),
      .buf_raddr     (buf_raddr),
      .buf_rdata     (buf_rdata)
   );

   rx_frame_dispatch u_rx_frame_dispatch (
      .clk          (clk),
      .reset        (reset),
      .init_done    (init_done),
      .rack_id      (rack_id),
      .slot_id      (slot_id),
      .hdr_valid    (hdr_valid),
      .hdr          (hdr),
      .drop_valid   (drop_valid),
      .drop_slot    (drop_slot),
      .desc_valid   (desc_valid),
      .desc         (desc),
      .desc_credit  (desc_credit),
      .notice_valid (notice_valid),
      .notice       (notice),
      .card_reset   (card_reset)
   );

   rx_ram_writer u_rx_ram_writer (
      .clk           (clk),
      .reset         (reset),
      .desc_valid    (desc_valid),
      .desc          (desc),
      .desc_credit   (desc_credit),
      .buf_rd        (buf_rd),
      .buf_raddr     (buf_raddr),
      .buf_rdata     (buf_rdata),
      .release_valid (release_valid),
      .release_slot  (release_slot),
      .ram_wr_valid  (ram_wr_valid),
      .ram_wr        (ram_wr)
   );

endmodule

//--- test/rx_frame_model.svh
// reference model for the receiver testbench; include inside the testbench module body
`ifndef RX_FRAME_MODEL_SVH
`define RX_FRAME_MODEL_SVH

// ------------------------------
// predictions
// ------------------------------
// drained by the output monitors, in order
rx_ram_wr_t exp_wr [$];
rx_notice_t exp_notice [$];
int         exp_crc = 0;
int         exp_card_reset = 0;
// reset frames since the last card reset or accepted data frame
int         reset_run = 0;

// card address, rack*12 + 14 - slot, wraps at 256
function automatic logic [7:0] station_of(input logic [2:0] rack_no, input logic [3:0] slot_no);
   int sum;
   sum = int'(rack_no) * 12 + 14 - int'(slot_no);
   return sum[7:0];
endfunction

// one complete frame as the link sent it
task automatic predict_frame(input logic [7:0] fb [`RX_FRAME_BYTES], input logic crc_ok,
                             input logic before_init, input logic [7:0] station);
   logic [7:0]            mode;
   logic [`RX_ADDR_W-1:0] addr;
   rx_ram_wr_t            wr;
   rx_notice_t            nt;
   int                    ofs;
   mode = fb[2];
   addr = {fb[3], fb[4], fb[5]};
   if (!crc_ok)
      exp_crc++;
   else if (!before_init && fb[0] == station)
   begin
      // data code 8'h60, modes 0..2 only
      if (fb[1] == 8'h60 && mode <= 8'd2)
      begin
         nt.mode = mode;
         nt.addr = addr;
         exp_notice.push_back(nt);
         reset_run = 0;
         for (int i = 0; i < `RX_PAY_BYTES; i++)
         begin
            ofs     = i - `RX_CMD_BYTES;
            wr.data = fb[`RX_HDR_BYTES + i];
            if (mode == 8'd2)
            begin
               wr.target = tgt_load;
               if (i < `RX_CMD_BYTES)
                  wr.addr = addr + `RX_ADDR_W'(i);
               else
                  wr.addr = addr + `RX_ADDR_W'(`RX_LOAD_DATA_OFS) + `RX_ADDR_W'(ofs);
            end
            else if (i < `RX_CMD_BYTES)
            begin
               wr.target = tgt_cmd;
               wr.addr   = (addr >> 4) + `RX_ADDR_W'(i);
            end
            else
            begin
               wr.target = tgt_cdata;
               wr.addr   = addr + `RX_ADDR_W'(ofs);
            end
            exp_wr.push_back(wr);
         end
      end
      // reset code 8'hff, any mode
      else if (fb[1] == 8'hff)
      begin
         reset_run++;
         if (reset_run == `RX_RESET_RUN)
         begin
            exp_card_reset++;
            reset_run = 0;
         end
      end
   end
endtask

`endif

//--- test/rx_link_receiver_tb.sv
// testbench for the link receiver; random credit-aware frames checked against a model
`timescale 1ns/100ps
`include "rx_params.svh"

module rx_link_receiver_tb
   import rx_frame_pkg::*, rx_store_pkg::*;
();

   localparam int reset_cycles    = 16;
   localparam int pre_frames      = 4;
   localparam int rand_frames     = 120;
   localparam int directed_frames = 9;
   localparam int total_frames    = pre_frames + rand_frames + directed_frames;
   // about 55 cycles per frame on the link plus reset and drain
   localparam int watchdog_cycles = total_frames * 60 + 3000;
   // two frames in the pipe at most, about 45 writer cycles each
   localparam int drain_cycles    = 200;
   localparam logic [2:0] rack    = 3'd5;
   localparam logic [3:0] slot    = 4'd9;

   // frame kinds for the driver
   localparam int kind_good  = 0;
   localparam int kind_crc   = 1;
   localparam int kind_da    = 2;
   localparam int kind_fc    = 3;
   localparam int kind_mode  = 4;
   localparam int kind_reset = 5;

   logic          clk;
   logic          reset;
   logic          init_done;
   logic [2:0]    rack_id;
   logic [3:0]    slot_id;
   logic          link_valid;
   rx_link_byte_t link_byte;
   logic          link_credit;
   logic          crc_err;
   logic          ram_wr_valid;
   rx_ram_wr_t    ram_wr;
   logic          notice_valid;
   rx_notice_t    notice;
   logic          card_reset;

   logic [7:0]    frame_bytes [`RX_FRAME_BYTES];
   logic          frame_crc;
   logic [7:0]    station;
   int            spent = 0;
   int            returned = 0;
   int            crc_seen = 0;
   int            resets_seen = 0;

   `include "rx_frame_model.svh"

   rx_link_receiver u_rx_link_receiver (
      .clk          (clk),
      .reset        (reset),
      .init_done    (init_done),
      .rack_id      (rack_id),
      .slot_id      (slot_id),
      .link_valid   (link_valid),
      .link_byte    (link_byte),
      .link_credit  (link_credit),
      .crc_err      (crc_err),
      .ram_wr_valid (ram_wr_valid),
      .ram_wr       (ram_wr),
      .notice_valid (notice_valid),
      .notice       (notice),
      .card_reset   (card_reset)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic report_error(input string msg);
      $display("[ERROR] %0t ns: %s", $time, msg);
      $display("Test FAILED");
      $fatal(1, "stopped at first error");
   endtask

   // ------------------------------
   // frame driver
   // ------------------------------
   // mostly good frames and a quarter resets
   function automatic int random_kind();
      int r;
      r = $urandom_range(99, 0);
      if (r < 35)
         return kind_good;
      else if (r < 45)
         return kind_crc;
      else if (r < 55)
         return kind_da;
      else if (r < 65)
         return kind_fc;
      else if (r < 75)
         return kind_mode;
      return kind_reset;
   endfunction

   // start from a good data frame and spoil one field
   task automatic build_frame(input int kind);
      logic [7:0] fc;
      for (int i = 0; i < `RX_FRAME_BYTES; i++)
         frame_bytes[i] = 8'($urandom_range(255, 0));
      frame_bytes[0] = station;
      frame_bytes[1] = 8'h60;
      frame_bytes[2] = 8'($urandom_range(2, 0));
      frame_crc      = 1'b1;
      fc             = 8'h60;
      case (kind)
         kind_crc:
            frame_crc = 1'b0;
         kind_da:
            frame_bytes[0] = station + 8'($urandom_range(255, 1));
         kind_fc:
         begin
            while (fc == 8'h60 || fc == 8'hff)
               fc = 8'($urandom_range(255, 0));
            frame_bytes[1] = fc;
         end
         kind_mode:
            frame_bytes[2] = 8'($urandom_range(255, 3));
         kind_reset:
         begin
            frame_bytes[1] = 8'hff;
            frame_bytes[2] = 8'($urandom_range(255, 0));
         end
         default:
            frame_crc = 1'b1;
      endcase
   endtask

   // entered and left on a falling edge
   task automatic send_frame(input logic before_init);
      while (spent - returned >= `RX_SLOTS)
         @(negedge clk);
      spent++;
      for (int i = 0; i < `RX_FRAME_BYTES; i++)
      begin
         // occasional idle cycles inside the frame
         if (i > 0 && $urandom_range(7, 0) == 0)
         begin
            link_valid = 1'b0;
            repeat ($urandom_range(2, 1)) @(negedge clk);
         end
         link_valid       = 1'b1;
         link_byte.data   = frame_bytes[i];
         link_byte.last   = (i == `RX_FRAME_BYTES - 1);
         link_byte.crc_ok = (i == `RX_FRAME_BYTES - 1) && frame_crc;
         if (i == `RX_FRAME_BYTES - 1)
            predict_frame(frame_bytes, frame_crc, before_init, station);
         @(negedge clk);
      end
      link_valid = 1'b0;
      link_byte  = '0;
   endtask

   // every slot comes back once the pipeline drains
   task automatic wait_credits_home();
      int waited;
      waited = 0;
      while (returned != spent && waited < drain_cycles)
      begin
         @(negedge clk);
         waited++;
      end
      assert (returned == spent)
      else report_error("link credits missing after the link went idle");
   endtask

   // ------------------------------
   // output monitors
   // ------------------------------
   // outputs are registered and steady at the falling edge
   always @(negedge clk)
   begin
      rx_ram_wr_t want_wr;
      rx_notice_t want_nt;
      if (link_credit)
      begin
         returned++;
         assert (returned <= spent)
         else report_error("link credit returned while no slot was in use");
      end
      if (crc_err)
      begin
         crc_seen++;
         assert (crc_seen <= exp_crc)
         else report_error($sformatf("crc_err pulse %0d not expected", crc_seen));
      end
      if (card_reset)
      begin
         resets_seen++;
         assert (resets_seen <= exp_card_reset)
         else report_error($sformatf("card_reset pulse %0d not expected", resets_seen));
      end
      if (notice_valid)
      begin
         assert (exp_notice.size() != 0)
         else report_error("notice with no accepted frame pending");
         want_nt = exp_notice.pop_front();
         assert (notice == want_nt)
         else report_error($sformatf("notice mode %h addr %h, want mode %h addr %h",
                                     notice.mode, notice.addr, want_nt.mode, want_nt.addr));
      end
      if (ram_wr_valid)
      begin
         assert (exp_wr.size() != 0)
         else report_error("RAM write with none pending");
         want_wr = exp_wr.pop_front();
         assert (ram_wr == want_wr)
         else report_error($sformatf(
            "write tgt %0d addr %h data %h, want tgt %0d addr %h data %h",
            ram_wr.target, ram_wr.addr, ram_wr.data,
            want_wr.target, want_wr.addr, want_wr.data));
      end
   end

   // ------------------------------
   // test sequence
   // ------------------------------
   initial
   begin
      reset      = 1'b1;
      init_done  = 1'b0;
      rack_id    = rack;
      slot_id    = slot;
      link_valid = 1'b0;
      link_byte  = '0;
      void'($urandom(32'hd4f7_a599));
      station = station_of(rack, slot);
      repeat (reset_cycles) @(negedge clk);
      assert (!link_credit && !crc_err && !ram_wr_valid && !notice_valid && !card_reset)
      else report_error("control output active during reset");
      reset = 1'b0;

      // good frames for this card, ignored until the card is initialized
      for (int n = 0; n < pre_frames; n++)
      begin
         build_frame(kind_good);
         send_frame(1'b1);
      end
      wait_credits_home();
      init_done = 1'b1;
      repeat (4) @(negedge clk);

      for (int n = 0; n < rand_frames; n++)
      begin
         build_frame(random_kind());
         send_frame(1'b0);
         repeat ($urandom_range(3, 0)) @(negedge clk);
      end

      // data frame clears the run before three resets and again before a full run
      for (int n = 0; n < directed_frames; n++)
      begin
         build_frame((n == 0 || n == 4) ? kind_good : kind_reset);
         send_frame(1'b0);
      end

      wait_credits_home();
      repeat (4) @(negedge clk);
      assert (exp_wr.size() == 0)
      else report_error($sformatf("%0d RAM writes never arrived", exp_wr.size()));
      assert (exp_notice.size() == 0)
      else report_error($sformatf("%0d notices never arrived", exp_notice.size()));
      assert (crc_seen == exp_crc)
      else report_error($sformatf("crc_err count %0d, want %0d", crc_seen, exp_crc));
      assert (resets_seen == exp_card_reset && exp_card_reset > 0)
      else report_error($sformatf("card_reset count %0d, want %0d",
                                  resets_seen, exp_card_reset));
      $display("Test OK");
      $finish;
   end

   // ------------------------------
   // watchdog
   // ------------------------------
   initial
   begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("timeout after %0d cycles, the run never reached its end", watchdog_cycles);
      $display("Test FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- files.f
+incdir+src
+incdir+test
src/rx_frame_pkg.sv
src/rx_store_pkg.sv
src/rx_frame_store.sv
src/rx_frame_dispatch.sv
src/rx_ram_writer.sv
src/rx_link_receiver.sv
test/rx_link_receiver_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile the receiver testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

top=rx_link_receiver_tb
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module "$top" -f files.f -o "$top"
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator compile failed with status $status"
   exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Test OK" "$log"; then
   echo "simulation passed"
   exit 0
else
   echo "pass message not found in $log"
   exit 1
fi
